// ==== cpu_params_pkg.sv ====
package cpu_params_pkg;

    // Width of operands, program counters and branch targets.
    localparam int XLEN = 32;

    // Width of a reorder buffer id, which allows 32 ids in flight.
    localparam int ROB_IDX = 5;

    // Default number of control buffer entries.
    // The top level may override this with any power of two from 2 up.
    localparam int CB_DEPTH_DEFAULT = 4;

    // Default number of retire slots granted by the ROB after reset.
    localparam int RETIRE_CREDITS_DEFAULT = 2;

endpackage

// ==== uop_types_pkg.sv ====
package uop_types_pkg;

    // Branch condition carried by a branch micro-op.
    // The LT and GE pair compares signed and the LTU and GEU pair compares unsigned.
    // BR_JAL ignores its sources and is always taken.
    typedef enum logic [2:0] {
        BR_EQ  = 3'd0,
        BR_NE  = 3'd1,
        BR_LT  = 3'd2,
        BR_GE  = 3'd3,
        BR_LTU = 3'd4,
        BR_GEU = 3'd5,
        BR_JAL = 3'd6
    } br_op_t;

endpackage

// ==== branch_dispatch.sv ====
module branch_dispatch #(
    parameter int CB_DEPTH = 4
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_valid,
    input  logic [cpu_params_pkg::ROB_IDX-1:0] in_rob_id,
    input  uop_types_pkg::br_op_t              in_op,
    input  logic [cpu_params_pkg::XLEN-1:0]    in_src1,
    input  logic [cpu_params_pkg::XLEN-1:0]    in_src2,
    input  logic [cpu_params_pkg::XLEN-1:0]    in_pc,
    input  logic [cpu_params_pkg::XLEN-1:0]    in_offset,
    input  logic                               in_pred_taken,
    input  logic                               credit_return,
    output logic                               in_ready,
    output logic                               alloc_valid,
    output logic [cpu_params_pkg::ROB_IDX-1:0] alloc_rob_id,
    output uop_types_pkg::br_op_t              ex_op,
    output logic [cpu_params_pkg::XLEN-1:0]    ex_src1,
    output logic [cpu_params_pkg::XLEN-1:0]    ex_src2,
    output logic [cpu_params_pkg::XLEN-1:0]    ex_pc,
    output logic [cpu_params_pkg::XLEN-1:0]    ex_offset,
    output logic                               ex_pred_taken
);

    localparam int CW = $clog2(CB_DEPTH + 1);

    logic [CW-1:0] credits;
    logic          accept;

    // One credit stands for one free control buffer entry.
    assign in_ready = (credits != '0);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits     <= CW'(CB_DEPTH);
            alloc_valid <= 1'b0;
        end else begin
            alloc_valid <= accept;
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alloc_rob_id  <= in_rob_id;
            ex_op         <= in_op;
            ex_src1       <= in_src1;
            ex_src2       <= in_src2;
            ex_pc         <= in_pc;
            ex_offset     <= in_offset;
            ex_pred_taken <= in_pred_taken;
        end
    end

    // Commit must never hand back more entries than dispatch gave out.
    credit_bound: assert property (@(posedge clk) disable iff (rst) credits <= CB_DEPTH)
        else $error("dispatch credit count above CB_DEPTH");

endmodule

// ==== branch_exec_pipe.sv ====
module branch_exec_pipe (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               alloc_valid,
    input  logic [cpu_params_pkg::ROB_IDX-1:0] alloc_rob_id,
    input  uop_types_pkg::br_op_t              ex_op,
    input  logic [cpu_params_pkg::XLEN-1:0]    ex_src1,
    input  logic [cpu_params_pkg::XLEN-1:0]    ex_src2,
    input  logic [cpu_params_pkg::XLEN-1:0]    ex_pc,
    input  logic [cpu_params_pkg::XLEN-1:0]    ex_offset,
    input  logic                               ex_pred_taken,
    output logic                               cdb_valid,
    output logic [cpu_params_pkg::ROB_IDX-1:0] cdb_rob_id,
    output logic                               cdb_miss_predict,
    output logic [cpu_params_pkg::XLEN-1:0]    cdb_target_address
);

    localparam logic [cpu_params_pkg::XLEN-1:0] INSN_BYTES = 4;

    logic                               taken;
    logic                               s1_valid;
    logic [cpu_params_pkg::ROB_IDX-1:0] s1_rob_id;
    logic                               s1_taken;
    logic                               s1_pred_taken;
    logic [cpu_params_pkg::XLEN-1:0]    s1_sum;
    logic [cpu_params_pkg::XLEN-1:0]    s1_pc;

    always_comb begin
        case (ex_op)
            uop_types_pkg::BR_EQ:  taken = (ex_src1 == ex_src2);
            uop_types_pkg::BR_NE:  taken = (ex_src1 != ex_src2);
            uop_types_pkg::BR_LT:  taken = ($signed(ex_src1) < $signed(ex_src2));
            uop_types_pkg::BR_GE:  taken = ($signed(ex_src1) >= $signed(ex_src2));
            uop_types_pkg::BR_LTU: taken = (ex_src1 < ex_src2);
            uop_types_pkg::BR_GEU: taken = (ex_src1 >= ex_src2);
            uop_types_pkg::BR_JAL: taken = 1'b1;
            default:               taken = 1'b0;
        endcase
    end

    // Stage 1 resolves the condition and forms the taken target.
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= alloc_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_rob_id     <= alloc_rob_id;
        s1_taken      <= taken;
        s1_pred_taken <= ex_pred_taken;
        s1_sum        <= ex_pc + ex_offset;
        s1_pc         <= ex_pc;
    end

    // Stage 2 selects the real next pc and compares against the prediction.
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb_rob_id         <= s1_rob_id;
        cdb_miss_predict   <= s1_taken ^ s1_pred_taken;
        cdb_target_address <= s1_taken ? s1_sum : s1_pc + INSN_BYTES;
    end

endmodule

// ==== control_buffer.sv ====
module control_buffer #(
    parameter int CB_DEPTH = 4
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               alloc_valid,
    input  logic [cpu_params_pkg::ROB_IDX-1:0] alloc_rob_id,
    input  logic                               cdb_valid,
    input  logic [cpu_params_pkg::ROB_IDX-1:0] cdb_rob_id,
    input  logic                               cdb_miss_predict,
    input  logic [cpu_params_pkg::XLEN-1:0]    cdb_target_address,
    input  logic                               dequeue,
    output logic                               head_valid,
    output logic                               head_resolved,
    output logic [cpu_params_pkg::ROB_IDX-1:0] head_rob_id,
    output logic                               head_miss_predict,
    output logic [cpu_params_pkg::XLEN-1:0]    head_target_address
);

    localparam int CB_IDX = $clog2(CB_DEPTH);

    logic [cpu_params_pkg::ROB_IDX-1:0] rob_id_q [CB_DEPTH];
    logic                               miss_q   [CB_DEPTH];
    logic [cpu_params_pkg::XLEN-1:0]    target_q [CB_DEPTH];
    logic [CB_DEPTH-1:0]                resolved_q;

    // The extra top bit of each pointer is the wrap flag.
    logic [CB_IDX:0]     wr_ptr;
    logic [CB_IDX:0]     rd_ptr;
    logic [CB_IDX-1:0]   wr_idx;
    logic [CB_IDX-1:0]   rd_idx;
    logic [CB_IDX:0]     count;
    logic                full;
    logic [CB_DEPTH-1:0] occupied;
    logic [CB_DEPTH-1:0] match;

    assign wr_idx = wr_ptr[CB_IDX-1:0];
    assign rd_idx = rd_ptr[CB_IDX-1:0];
    assign count  = wr_ptr - rd_ptr;
    assign full   = (wr_idx == rd_idx) && (wr_ptr[CB_IDX] != rd_ptr[CB_IDX]);

    // A slot is live when its distance from the head is below the fill count.
    // Stale slots may still hold an old id that the result bus happens to reuse.
    always_comb begin
        for (int i = 0; i < CB_DEPTH; i++) begin
            occupied[i] = {1'b0, CB_IDX'(CB_IDX'(i) - rd_idx)} < count;
            match[i]    = cdb_valid && occupied[i] && (rob_id_q[i] == cdb_rob_id);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            resolved_q <= '0;
        end else begin
            if (alloc_valid) begin
                resolved_q[wr_idx] <= 1'b0;
                wr_ptr             <= wr_ptr + 1'b1;
            end
            for (int i = 0; i < CB_DEPTH; i++) begin
                if (match[i]) begin
                    resolved_q[i] <= 1'b1;
                end
            end
            if (dequeue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            rob_id_q[wr_idx] <= alloc_rob_id;
        end
        for (int i = 0; i < CB_DEPTH; i++) begin
            if (match[i]) begin
                miss_q[i]   <= cdb_miss_predict;
                target_q[i] <= cdb_target_address;
            end
        end
    end

    assign head_valid          = (wr_ptr != rd_ptr);
    assign head_resolved       = resolved_q[rd_idx];
    assign head_rob_id         = rob_id_q[rd_idx];
    assign head_miss_predict   = miss_q[rd_idx];
    assign head_target_address = target_q[rd_idx];

    // Dispatch credits must keep allocation away from a full queue.
    no_alloc_full: assert property (@(posedge clk) disable iff (rst) alloc_valid |-> !full)
        else $error("allocation into a full control buffer");

    no_early_pop: assert property (@(posedge clk) disable iff (rst)
        dequeue |-> head_valid && head_resolved)
        else $error("dequeue of an empty or unresolved head");

endmodule

// ==== branch_commit.sv ====
module branch_commit #(
    parameter int RETIRE_CREDITS = 2
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               head_valid,
    input  logic                               head_resolved,
    input  logic [cpu_params_pkg::ROB_IDX-1:0] head_rob_id,
    input  logic                               head_miss_predict,
    input  logic [cpu_params_pkg::XLEN-1:0]    head_target_address,
    input  logic                               retire_credit,
    output logic                               dequeue,
    output logic                               credit_return,
    output logic                               retire_valid,
    output logic [cpu_params_pkg::ROB_IDX-1:0] retire_rob_id,
    output logic                               retire_miss_predict,
    output logic [cpu_params_pkg::XLEN-1:0]    retire_target_address
);

    localparam int CW = $clog2(RETIRE_CREDITS + 1);

    logic [CW-1:0] credits;
    logic          fire;

    // The head is popped on the edge after dequeue rises, so a head that is
    // already leaving is not retired a second time.
    assign fire = head_valid && head_resolved && (credits != '0) && !dequeue;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CW'(RETIRE_CREDITS);
            dequeue <= 1'b0;
        end else begin
            dequeue <= fire;
            case ({fire, retire_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            retire_rob_id         <= head_rob_id;
            retire_miss_predict   <= head_miss_predict;
            retire_target_address <= head_target_address;
        end
    end

    // Each retire frees one control buffer entry back to dispatch.
    assign credit_return = dequeue;
    assign retire_valid  = dequeue;

    rob_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= RETIRE_CREDITS)
        else $error("ROB returned more retire credits than were spent");

endmodule

// ==== branch_unit_top.sv ====
module branch_unit_top #(
    parameter int CB_DEPTH       = cpu_params_pkg::CB_DEPTH_DEFAULT,
    parameter int RETIRE_CREDITS = cpu_params_pkg::RETIRE_CREDITS_DEFAULT
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_valid,
    input  logic [cpu_params_pkg::ROB_IDX-1:0] in_rob_id,
    input  uop_types_pkg::br_op_t              in_op,
    input  logic [cpu_params_pkg::XLEN-1:0]    in_src1,
    input  logic [cpu_params_pkg::XLEN-1:0]    in_src2,
    input  logic [cpu_params_pkg::XLEN-1:0]    in_pc,
    input  logic [cpu_params_pkg::XLEN-1:0]    in_offset,
    input  logic                               in_pred_taken,
    output logic                               in_ready,
    input  logic                               retire_credit,
    output logic                               retire_valid,
    output logic [cpu_params_pkg::ROB_IDX-1:0] retire_rob_id,
    output logic                               retire_miss_predict,
    output logic [cpu_params_pkg::XLEN-1:0]    retire_target_address
);

    logic                               alloc_valid;
    logic [cpu_params_pkg::ROB_IDX-1:0] alloc_rob_id;
    uop_types_pkg::br_op_t              ex_op;
    logic [cpu_params_pkg::XLEN-1:0]    ex_src1;
    logic [cpu_params_pkg::XLEN-1:0]    ex_src2;
    logic [cpu_params_pkg::XLEN-1:0]    ex_pc;
    logic [cpu_params_pkg::XLEN-1:0]    ex_offset;
    logic                               ex_pred_taken;
    logic                               cdb_valid;
    logic [cpu_params_pkg::ROB_IDX-1:0] cdb_rob_id;
    logic                               cdb_miss_predict;
    logic [cpu_params_pkg::XLEN-1:0]    cdb_target_address;
    logic                               head_valid;
    logic                               head_resolved;
    logic [cpu_params_pkg::ROB_IDX-1:0] head_rob_id;
    logic                               head_miss_predict;
    logic [cpu_params_pkg::XLEN-1:0]    head_target_address;
    logic                               dequeue;
    logic                               credit_return;

    branch_dispatch #(.CB_DEPTH(CB_DEPTH)) u_dispatch (
        .clk, .rst, .in_valid, .in_rob_id, .in_op, .in_src1, .in_src2, .in_pc,
        .in_offset, .in_pred_taken, .credit_return, .in_ready, .alloc_valid,
        .alloc_rob_id, .ex_op, .ex_src1, .ex_src2, .ex_pc, .ex_offset, .ex_pred_taken
    );

    branch_exec_pipe u_exec (
        .clk, .rst, .alloc_valid, .alloc_rob_id, .ex_op, .ex_src1, .ex_src2, .ex_pc,
        .ex_offset, .ex_pred_taken, .cdb_valid, .cdb_rob_id, .cdb_miss_predict,
        .cdb_target_address
    );

    control_buffer #(.CB_DEPTH(CB_DEPTH)) u_buffer (
        .clk, .rst, .alloc_valid, .alloc_rob_id, .cdb_valid, .cdb_rob_id,
        .cdb_miss_predict, .cdb_target_address, .dequeue, .head_valid, .head_resolved,
        .head_rob_id, .head_miss_predict, .head_target_address
    );

    branch_commit #(.RETIRE_CREDITS(RETIRE_CREDITS)) u_commit (
        .clk, .rst, .head_valid, .head_resolved, .head_rob_id, .head_miss_predict,
        .head_target_address, .retire_credit, .dequeue, .credit_return, .retire_valid,
        .retire_rob_id, .retire_miss_predict, .retire_target_address
    );

endmodule

// ==== tb_branch_unit.sv ====
module tb_branch_unit;

    localparam int CB_DEPTH       = 4;
    localparam int RETIRE_CREDITS = 2;
    localparam int N_LINES        = 20;
    localparam int FIELDS         = 9;
    localparam int TIMEOUT        = 40 * N_LINES + 100;

    logic                               clk;
    logic                               rst;
    logic                               in_valid;
    logic [cpu_params_pkg::ROB_IDX-1:0] in_rob_id;
    uop_types_pkg::br_op_t              in_op;
    logic [cpu_params_pkg::XLEN-1:0]    in_src1;
    logic [cpu_params_pkg::XLEN-1:0]    in_src2;
    logic [cpu_params_pkg::XLEN-1:0]    in_pc;
    logic [cpu_params_pkg::XLEN-1:0]    in_offset;
    logic                               in_pred_taken;
    logic                               in_ready;
    logic                               retire_credit;
    logic                               retire_valid;
    logic [cpu_params_pkg::ROB_IDX-1:0] retire_rob_id;
    logic                               retire_miss_predict;
    logic [cpu_params_pkg::XLEN-1:0]    retire_target_address;

    logic [31:0] trace_mem [N_LINES*FIELDS];
    logic [31:0] gap_state;
    logic [31:0] credit_state;
    logic        ready_fell;
    int          errors;
    int          retires_seen;
    int          credits_given;
    int          exp_credits;
    int          rob_credits;
    int          cycle_count;

    branch_unit_top #(.CB_DEPTH(CB_DEPTH), .RETIRE_CREDITS(RETIRE_CREDITS)) UUT (
        .clk, .rst, .in_valid, .in_rob_id, .in_op, .in_src1, .in_src2, .in_pc,
        .in_offset, .in_pred_taken, .in_ready, .retire_credit, .retire_valid,
        .retire_rob_id, .retire_miss_predict, .retire_target_address
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Fail %0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    // Holds one trace line on the inputs until an edge sees in_ready high.
    task automatic drive_uop(input int line);
        int   base;
        logic ready_seen;
        base = line * FIELDS;
        in_valid      <= 1'b1;
        in_rob_id     <= trace_mem[base][cpu_params_pkg::ROB_IDX-1:0];
        in_op         <= uop_types_pkg::br_op_t'(trace_mem[base+1][2:0]);
        in_src1       <= trace_mem[base+2];
        in_src2       <= trace_mem[base+3];
        in_pc         <= trace_mem[base+4];
        in_offset     <= trace_mem[base+5];
        in_pred_taken <= trace_mem[base+6][0];
        ready_seen = 1'b0;
        while (!ready_seen) begin
            @(negedge clk);
            ready_seen = in_ready;
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        int gap;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_rob_id     = '0;
        in_op         = uop_types_pkg::BR_EQ;
        in_src1       = '0;
        in_src2       = '0;
        in_pc         = '0;
        in_offset     = '0;
        in_pred_taken = 1'b0;
        retire_credit = 1'b0;
        errors        = 0;
        retires_seen  = 0;
        credits_given = 0;
        ready_fell    = 1'b0;
        gap_state     = 32'd50;
        credit_state  = 32'd50;
        $readmemh("branch_trace.txt", trace_mem);
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (in_ready !== 1'b1) report_mismatch("in_ready", 32'd1, in_ready);
        if (retire_valid !== 1'b0) report_mismatch("retire_valid", 32'd0, retire_valid);
        @(posedge clk);
        for (int i = 0; i < N_LINES; i++) begin
            gap_state = lcg_next(gap_state);
            gap = (gap_state >> 16) % 3;
            if (gap > 0) begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            drive_uop(i);
        end
        in_valid <= 1'b0;
        wait (retires_seen == N_LINES);
        repeat (20) @(posedge clk);
        if (!ready_fell) begin
            errors++;
            $display("in_ready never fell while the ROB was holding back credits");
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // ROB model. The first slot is freed late so that the control buffer fills up.
    initial begin
        int delay;
        wait (rst === 1'b0);
        forever begin
            @(posedge clk);
            if (retires_seen > credits_given) begin
                credit_state = lcg_next(credit_state);
                if (credits_given == 0) begin
                    delay = 30;
                end else begin
                    delay = (credit_state >> 16) % 6;
                end
                repeat (delay) @(posedge clk);
                retire_credit <= 1'b1;
                credits_given++;
                @(posedge clk);
                retire_credit <= 1'b0;
            end
        end
    end

    // Outputs only change on rising edges, so they are sampled on falling ones.
    always @(negedge clk) begin
        int base;
        if (rst) begin
            exp_credits = CB_DEPTH;
            rob_credits = RETIRE_CREDITS;
        end else begin
            if (in_ready !== (exp_credits != 0)) begin
                report_mismatch("in_ready", 32'(exp_credits != 0), in_ready);
            end
            if (!in_ready) ready_fell = 1'b1;
            if (in_valid && in_ready) exp_credits--;
            if (retire_valid) begin
                if (rob_credits == 0) begin
                    errors++;
                    $display("Retire at %0t without a free ROB slot", $time);
                end else begin
                    rob_credits--;
                end
                if (retires_seen >= N_LINES) begin
                    errors++;
                    $display("Extra retire at %0t after the last trace line", $time);
                end else begin
                    base = retires_seen * FIELDS;
                    if (retire_rob_id !== trace_mem[base][cpu_params_pkg::ROB_IDX-1:0]) begin
                        report_mismatch("retire_rob_id", trace_mem[base], retire_rob_id);
                    end
                    if (retire_miss_predict !== trace_mem[base+7][0]) begin
                        report_mismatch("retire_miss_predict", trace_mem[base+7],
                                        retire_miss_predict);
                    end
                    if (retire_target_address !== trace_mem[base+8]) begin
                        report_mismatch("retire_target_address", trace_mem[base+8],
                                        retire_target_address);
                    end
                end
                retires_seen++;
                exp_credits++;
            end
            if (retire_credit) rob_credits++;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT) begin
            @(posedge clk);
            cycle_count++;
        end
        errors++;
        $display("Timeout after %0d cycles, retires are missing: %0d of %0d seen",
                 cycle_count, retires_seen, N_LINES);
        $display("Errors: %0d", errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== branch_trace.txt ====
// rob_id op src1 src2 pc offset pred_taken | expected miss_predict and target, all hex
// op: 0 EQ, 1 NE, 2 LT, 3 GE, 4 LTU, 5 GEU, 6 JAL
01 0 00000005 00000005 00001000 00000010 1 0 00001010
02 0 00000005 00000006 00001004 00000020 1 1 00001008
03 1 00000005 00000006 00001008 fffffff0 0 1 00000ff8
04 1 00000007 00000007 0000100c 00000040 0 0 00001010
05 2 ffffffff 00000001 00001010 00000008 1 0 00001018
06 4 ffffffff 00000001 00001014 0000000c 1 1 00001018
07 3 fffffffe 00000003 00001018 00000100 0 0 0000101c
08 5 fffffffe 00000003 0000101c 00000100 0 1 0000111c
09 6 00000000 00000000 00001020 00000200 1 0 00001220
0a 6 12345678 00000000 00001024 fffff000 0 1 00000024
0b 2 00000003 fffffffd 00002000 00000030 1 1 00002004
0c 4 00000003 fffffffd 00002004 00000030 1 0 00002034
0d 3 80000000 7fffffff 00002008 00000010 0 0 0000200c
0e 5 80000000 7fffffff 0000200c 00000010 0 1 0000201c
0f 0 00000000 00000000 fffffff8 00000010 1 0 00000008
10 1 00000000 00000001 00003000 fffffffc 1 0 00002ffc
11 3 00000005 00000005 00003004 00000020 1 0 00003024
12 2 00000005 00000005 00003008 00000020 0 0 0000300c
13 5 00000000 00000001 0000300c 00000008 1 1 00003010
14 4 00000000 00000001 00003010 00000008 0 1 00003018

// ==== project.f ====
cpu_params_pkg.sv
uop_types_pkg.sv
branch_dispatch.sv
branch_exec_pipe.sv
control_buffer.sv
branch_commit.sv
branch_unit_top.sv
tb_branch_unit.sv

// ==== Bender.yml ====
package:
  name: branch_unit

sources:
  - cpu_params_pkg.sv
  - uop_types_pkg.sv
  - branch_dispatch.sv
  - branch_exec_pipe.sv
  - control_buffer.sv
  - branch_commit.sv
  - branch_unit_top.sv
  - target: test
    files:
      - tb_branch_unit.sv
